/* fetch_align.f */
+incdir+source
+incdir+sim
source/fetch_align_pkg.sv
source/fetch_word_if.sv
source/issue_if.sv
source/fetch_prefetch_buffer.sv
source/instr_aligner.sv
source/issue_stage_reg.sv
source/fetch_align_top.sv
sim/fetch_align_tb.sv

/* sim/fetch_align_tb_ref.svh */
/*
  Fetch front end reference model
  Walks the program image from the current pc and predicts the
  pc, instruction and compressed flag of every issued instruction
*/
`ifndef FETCH_ALIGN_TB_REF_SVH
`define FETCH_ALIGN_TB_REF_SVH

logic [31:0] ref_pc;
logic [31:0] exp_pc_q[$];
logic [31:0] exp_instr_q[$];
logic        exp_c_q[$];

// the image wraps every 256 bytes, exactly like the memory model
function automatic logic [15:0] ref_half(input logic [31:0] addr);
  logic [31:0] w;
  w = image[addr[7:2]];
  return addr[1] ? w[31:16] : w[15:0];
endfunction

// a parcel ending in two ones opens a 32-bit instruction
function automatic void ref_push_next();
  logic [15:0] lo;
  logic [15:0] hi;
  lo = ref_half(ref_pc);
  exp_pc_q.push_back(ref_pc);
  if (lo[1:0] == 2'b11) begin
    hi = ref_half(ref_pc + 32'd2);
    exp_instr_q.push_back({hi, lo});
    exp_c_q.push_back(1'b0);
    ref_pc = ref_pc + 32'd4;
  end else begin
    exp_instr_q.push_back({16'b0, lo});
    exp_c_q.push_back(1'b1);
    ref_pc = ref_pc + 32'd2;
  end
endfunction

// keep a few predictions ahead of the DUT
function automatic void ref_top_up();
  while (exp_pc_q.size() < 4) begin
    ref_push_next();
  end
endfunction

// a parked jump keeps the stalled instruction at the head
function automatic void ref_redirect(input logic [31:0] target, input bit keep_head);
  while (exp_pc_q.size() > (keep_head ? 1 : 0)) begin
    void'(exp_pc_q.pop_back());
    void'(exp_instr_q.pop_back());
    void'(exp_c_q.pop_back());
  end
  ref_pc = target;
  ref_top_up();
endfunction

`endif

/* sim/fetch_align_tb.sv */
/*
  Fetch front end testbench
  Memory model with random latency, a table of branch, stall and
  hold events, and checks of every issued instruction
*/
`timescale 1ns/100ps
`include "fetch_align_macros.svh"

module fetch_align_tb;
  import fetch_align_pkg::*;

  typedef struct {
    bit          br;
    logic [31:0] start_pc;
    bit          jump;
    int          stall;
    bit          hold;
    int          n_issue;
  } event_t;

  logic        clk = 1'b0;
  logic        rst_n = 1'b0;
  logic        mem_req_o;
  addr_t       mem_addr_o;
  word_t       mem_rdata_i = '0;
  logic        mem_rvalid_i = 1'b0;
  logic        branch_i = 1'b0;
  addr_t       branch_addr_i = '0;
  logic        branch_is_jump_i = 1'b0;
  logic        hold_state_i = 1'b0;
  logic        id_ready_i = 1'b1;
  instr_t      id_instr_o;
  addr_t       id_pc_o;
  logic        id_compressed_o;
  logic        id_valid_o;
  logic [31:0] image [64];
  event_t      tab [8];
  int unsigned cyc = 0;
  int unsigned limit = 0;
  int unsigned due;
  int unsigned last_due;
  int unsigned resp_due_q[$];
  addr_t       resp_addr_q[$];
  int          n_errors = 0;
  int          n_checks = 0;
  int          n_accept = 0;
  bit          stall_prev = 1'b0;
  logic [31:0] held_pc;
  logic [31:0] held_instr;

  `include "fetch_align_tb_ref.svh"

  fetch_align_top u_dut (.*);

  initial begin
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////
  // memory model, in order, 1 to 3 cycles
  ////////////////////////////////////////
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_rvalid_i <= 1'b0;
      resp_due_q.delete();
      resp_addr_q.delete();
      last_due = 0;
    end else begin
      mem_rvalid_i <= 1'b0;
      if (resp_due_q.size() != 0 && resp_due_q[0] <= cyc) begin
        mem_rvalid_i <= 1'b1;
        mem_rdata_i  <= image[resp_addr_q[0][7:2]];
        void'(resp_due_q.pop_front());
        void'(resp_addr_q.pop_front());
      end
      if (mem_req_o) begin
        // only whole words are ever requested, even after a misaligned target
        compare_value("mem_addr_o[1:0]", 32'(mem_addr_o[1:0]), 32'd0);
        due = cyc + 1 + ($urandom % 3);
        // responses never overtake each other
        if (due <= last_due) due = last_due + 1;
        last_due = due;
        resp_due_q.push_back(due);
        resp_addr_q.push_back(mem_addr_o);
      end
    end
  end

  // cycle count and run limit
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (limit != 0 && cyc >= limit) begin
      $display("timeout: the run did not finish within %0d cycles", limit);
      $display("checks %0d, errors %0d", n_checks, n_errors);
      $display("Result: FAILED");
      $finish;
    end
  end

  task automatic compare_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    assert (got === exp) else begin
      $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
      n_errors++;
    end
  endtask

  ////////////////////////////////////////
  // issue monitor
  ////////////////////////////////////////
  always @(posedge clk) begin
    if (rst_n) begin
      // a stalled instruction must sit still until decode takes it
      if (stall_prev) begin
        compare_value("id_valid_o", 32'(id_valid_o), 32'd1);
        compare_value("id_pc_o", id_pc_o, held_pc);
        compare_value("id_instr_o", id_instr_o, held_instr);
      end
      stall_prev = id_valid_o && !id_ready_i && !branch_i;
      held_pc    = id_pc_o;
      held_instr = id_instr_o;
      if (id_valid_o && id_ready_i) begin
        compare_value("id_pc_o", id_pc_o, exp_pc_q.pop_front());
        compare_value("id_instr_o", id_instr_o, exp_instr_q.pop_front());
        compare_value("id_compressed_o", 32'(id_compressed_o), 32'(exp_c_q.pop_front()));
        n_accept++;
        ref_top_up();
      end
      if (branch_i) begin
        ref_redirect(branch_addr_i, branch_is_jump_i && id_valid_o && !id_ready_i);
      end
    end
  end

  task automatic fire_branch(input int e);
    @(posedge clk);
    branch_i         <= 1'b1;
    branch_addr_i    <= tab[e].start_pc;
    branch_is_jump_i <= tab[e].jump;
    @(posedge clk);
    branch_i         <= 1'b0;
    branch_is_jump_i <= 1'b0;
  endtask

  task automatic run_event(input int e);
    int target;
    if (tab[e].stall != 0) begin
      @(posedge clk);
      id_ready_i <= 1'b0;
      // stall only once decode actually holds an instruction
      do @(negedge clk); while (!id_valid_o);
      if (tab[e].br) fire_branch(e);
      repeat (tab[e].stall + ($urandom % 16)) @(posedge clk);
      id_ready_i <= 1'b1;
    end else if (tab[e].br) begin
      fire_branch(e);
    end
    if (tab[e].hold) begin
      @(posedge clk);
      hold_state_i <= 1'b1;
      @(posedge clk);
      hold_state_i <= 1'b0;
    end
    target = n_accept + tab[e].n_issue;
    while (n_accept < target) @(posedge clk);
  endtask

  // forces the length of the instruction that starts at addr
  function automatic void set_len(input logic [7:0] addr, input bit is32);
    if (addr[1]) image[addr[7:2]][17:16] = is32 ? 2'b11 : 2'b01;
    else image[addr[7:2]][1:0] = is32 ? 2'b11 : 2'b01;
  endfunction

  initial begin
    logic [7:0] a;
    void'($urandom(19));
    // upper parcel bits follow the address, the length bits are random
    for (int w = 0; w < 64; w++) begin
      for (int h = 0; h < 2; h++) begin
        a = 8'(w * 4 + h * 2);
        image[w][h*16 +: 16] = {a[7:1] ^ 7'h35, 7'($urandom),
                                ($urandom % 2) ? 2'b11 : 2'($urandom % 3)};
      end
    end
    set_len(8'h4A, 1'b0);
    set_len(8'h86, 1'b1);
    set_len(8'h36, 1'b1);
    //      br    start_pc  jump  stall hold  n_issue
    tab[0] = '{1'b0, 32'h00, 1'b0, 0,    1'b0, 24};
    tab[1] = '{1'b1, 32'h4A, 1'b0, 0,    1'b0, 8};
    tab[2] = '{1'b1, 32'h86, 1'b0, 0,    1'b1, 8};
    tab[3] = '{1'b1, 32'hC0, 1'b1, 4,    1'b0, 8};
    tab[4] = '{1'b1, 32'h22, 1'b0, 3,    1'b0, 8};
    tab[5] = '{1'b0, 32'h00, 1'b0, 10,   1'b1, 12};
    tab[6] = '{1'b0, 32'h00, 1'b0, 6,    1'b0, 12};
    tab[7] = '{1'b1, 32'h36, 1'b1, 0,    1'b1, 10};
    for (int e = 0; e < 8; e++) begin
      limit += 20 * (tab[e].n_issue + tab[e].stall + 20);
    end
    limit += 400;
    ref_redirect(`FA_RESET_PC, 1'b0);
    repeat (8) @(posedge clk);
    @(negedge clk);
    compare_value("id_valid_o", 32'(id_valid_o), 32'd0);
    compare_value("mem_req_o", 32'(mem_req_o), 32'd0);
    @(posedge clk);
    rst_n <= 1'b1;
    for (int e = 0; e < 8; e++) begin
      run_event(e);
    end
    repeat (4) @(posedge clk);
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* source/fetch_align_macros.svh */
/*
  Fetch front end parameters
  Word width, reset program counter and prefetch queue depth
  shared by the package and the RTL blocks
*/
`ifndef FETCH_ALIGN_MACROS_SVH
`define FETCH_ALIGN_MACROS_SVH

// width of one memory word and of one uncompressed instruction
`define FA_WORD_W 32

// first pc fetched and issued after reset
`define FA_RESET_PC 32'h0000_0000

// number of words the prefetch buffer may own at once
// this counts both queued words and requests still in flight
// two is enough for back-to-back fetch, four also works
`define FA_PF_DEPTH 2

`endif

/* source/fetch_align_pkg.sv */
/*
  Fetch front end types
  Vector types for words, parcels and addresses, and the
  state encoding of the instruction aligner
*/
`include "fetch_align_macros.svh"

package fetch_align_pkg;

  // one aligned word as returned by instruction memory
  typedef logic [`FA_WORD_W-1:0] word_t;
  // one instruction, a compressed one sits zero-extended in the low half
  typedef logic [`FA_WORD_W-1:0] instr_t;
  // one 16-bit instruction parcel
  typedef logic [15:0] half_t;
  // byte address
  typedef logic [31:0] addr_t;

  // aligner states, named after the alignment of the last instruction taken
  typedef enum logic [2:0] {
    ALIGNED32,
    ALIGNED16,
    MISALIGNED32,
    MISALIGNED16,
    BRANCH_MISALIGNED,
    WAIT_VALID_BRANCH
  } align_state_e;

endpackage

/* source/fetch_align_top.sv */
/*
  Instruction fetch front end
  Prefetch buffer, aligner and issue register wired together,
  with plain ports towards memory, control and decode
*/
`timescale 1ns/100ps
`include "fetch_align_macros.svh"

module fetch_align_top (
  input  logic                    clk,
  input  logic                    rst_n,
  // instruction memory, one in-order response per request
  output logic                    mem_req_o,
  output fetch_align_pkg::addr_t  mem_addr_o,
  input  fetch_align_pkg::word_t  mem_rdata_i,
  input  logic                    mem_rvalid_i,
  // redirect and pipeline control
  input  logic                    branch_i,
  input  fetch_align_pkg::addr_t  branch_addr_i,
  input  logic                    branch_is_jump_i,
  input  logic                    hold_state_i,
  input  logic                    id_ready_i,
  // towards decode
  output fetch_align_pkg::instr_t id_instr_o,
  output fetch_align_pkg::addr_t  id_pc_o,
  output logic                    id_compressed_o,
  output logic                    id_valid_o
);

  fetch_word_if u_fw_if ();
  issue_if      u_is_if ();

  // word fetch and queue
  fetch_prefetch_buffer #(
    .PF_DEPTH (`FA_PF_DEPTH)
  ) u_prefetch (
    .clk          (clk),
    .rst_n        (rst_n),
    .mem_req_o    (mem_req_o),
    .mem_addr_o   (mem_addr_o),
    .mem_rdata_i  (mem_rdata_i),
    .mem_rvalid_i (mem_rvalid_i),
    .fw           (u_fw_if.buffer)
  );

  // the aligner also forwards the branch to the queue
  instr_aligner u_aligner (
    .clk              (clk),
    .rst_n            (rst_n),
    .fw               (u_fw_if.aligner),
    .is               (u_is_if.source),
    .branch_i         (branch_i),
    .branch_addr_i    (branch_addr_i),
    .branch_is_jump_i (branch_is_jump_i),
    .hold_state_i     (hold_state_i)
  );

  issue_stage_reg u_issue (
    .clk             (clk),
    .rst_n           (rst_n),
    .is              (u_is_if.sink),
    .id_ready_i      (id_ready_i),
    .branch_i        (branch_i),
    .id_instr_o      (id_instr_o),
    .id_pc_o         (id_pc_o),
    .id_compressed_o (id_compressed_o),
    .id_valid_o      (id_valid_o)
  );

endmodule

/* source/fetch_prefetch_buffer.sv */
/*
  Prefetch buffer
  Requests aligned words from instruction memory, counts the
  responses in flight and queues the returned words for the aligner.
  A branch flushes the queue and marks the outstanding responses
  as stale so they are dropped on arrival
*/
`timescale 1ns/100ps
`include "fetch_align_macros.svh"

module fetch_prefetch_buffer #(
  parameter int unsigned PF_DEPTH = `FA_PF_DEPTH
) (
  input  logic                   clk,
  input  logic                   rst_n,
  output logic                   mem_req_o,
  output fetch_align_pkg::addr_t mem_addr_o,
  input  fetch_align_pkg::word_t mem_rdata_i,
  input  logic                   mem_rvalid_i,
  fetch_word_if.buffer           fw
);
  import fetch_align_pkg::*;

  localparam int unsigned CNT_W = $clog2(PF_DEPTH + 1);
  localparam int unsigned PTR_W = (PF_DEPTH > 1) ? $clog2(PF_DEPTH) : 1;

  word_t            queue_mem [PF_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] q_cnt_q;
  logic [CNT_W-1:0] inflight_q;
  logic [CNT_W-1:0] drop_q;
  logic [CNT_W:0]   occupancy;
  addr_t            req_addr_q;
  logic             run_q;
  logic             push;
  logic             pop;

  ////////////////////////////////////////
  // request side
  ////////////////////////////////////////

  // every word we own, queued or still on the bus
  assign occupancy  = inflight_q + q_cnt_q;
  // no request in the branch cycle, the address is being reloaded
  assign mem_req_o  = run_q && !fw.branch && (occupancy < (CNT_W + 1)'(PF_DEPTH));
  assign mem_addr_o = req_addr_q;

  ////////////////////////////////////////
  // queue side
  ////////////////////////////////////////

  // stale responses are swallowed until the drop count runs out
  assign push = mem_rvalid_i && (drop_q == '0) && !fw.branch;
  // a hold from the aligner keeps the head for the next parcel
  assign pop  = fw.advance && !fw.hold && (q_cnt_q != '0) && !fw.branch;

  assign fw.valid = (q_cnt_q != '0);
  assign fw.word  = queue_mem[rd_ptr_q];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run_q      <= 1'b0;
      req_addr_q <= `FA_RESET_PC;
      inflight_q <= '0;
      drop_q     <= '0;
      q_cnt_q    <= '0;
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
    end else begin
      // requests start one cycle after reset is released
      run_q      <= 1'b1;
      inflight_q <= inflight_q + CNT_W'(mem_req_o) - CNT_W'(mem_rvalid_i);
      if (fw.branch) begin
        // everything still on the bus belongs to the old stream
        req_addr_q <= {fw.branch_addr[31:2], 2'b00};
        drop_q     <= inflight_q - CNT_W'(mem_rvalid_i);
        q_cnt_q    <= '0;
        wr_ptr_q   <= '0;
        rd_ptr_q   <= '0;
      end else begin
        if (mem_req_o) begin
          req_addr_q <= req_addr_q + addr_t'(4);
        end
        if (mem_rvalid_i && (drop_q != '0)) begin
          drop_q <= drop_q - 1'b1;
        end
        if (push) begin
          wr_ptr_q <= (wr_ptr_q == PTR_W'(PF_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
        end
        if (pop) begin
          rd_ptr_q <= (rd_ptr_q == PTR_W'(PF_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
        end
        if (push && !pop) begin
          q_cnt_q <= q_cnt_q + 1'b1;
        end else if (pop && !push) begin
          q_cnt_q <= q_cnt_q - 1'b1;
        end
      end
    end
  end

  // queue storage
  always_ff @(posedge clk) begin
    if (push) begin
      queue_mem[wr_ptr_q] <= mem_rdata_i;
    end
  end

  // memory must answer only what was asked, and there is always room for it
  a_no_overflow: assert property (
    @(posedge clk) disable iff (!rst_n)
    mem_rvalid_i |-> (inflight_q != '0) && (q_cnt_q < CNT_W'(PF_DEPTH))
  );

endmodule

/* source/fetch_word_if.sv */
/*
  Fetched word channel
  Carries the head of the prefetch queue to the aligner and the
  hold, advance and branch strobes back to the queue
*/
`timescale 1ns/100ps

interface fetch_word_if;
  import fetch_align_pkg::*;

  // head of the queue and its valid level
  word_t word;
  logic  valid;
  // aligner keeps the head in place for one more cycle
  logic  hold;
  // aligner moved on and the head may be popped
  logic  advance;
  // flush the queue and restart fetch at the target word
  logic  branch;
  addr_t branch_addr;

  modport buffer (
    output word, valid,
    input  hold, advance, branch, branch_addr
  );

  modport aligner (
    input  word, valid,
    output hold, advance, branch, branch_addr
  );

endinterface

/* source/instr_aligner.sv */
/*
  Instruction aligner
  Cuts the fetched word stream into 16-bit and 32-bit instructions,
  keeps the upper parcel of the last word for instructions that
  straddle a word boundary, and tracks the pc of the offered one.
  Handles misaligned branch targets, a jump parked during a decode
  stall, and the one-cycle pc freeze after an ecall
*/
`timescale 1ns/100ps
`include "fetch_align_macros.svh"

module instr_aligner (
  input  logic                   clk,
  input  logic                   rst_n,
  fetch_word_if.aligner          fw,
  issue_if.source                is,
  input  logic                   branch_i,
  input  fetch_align_pkg::addr_t branch_addr_i,
  input  logic                   branch_is_jump_i,
  input  logic                   hold_state_i
);
  import fetch_align_pkg::*;

  align_state_e state_q;
  align_state_e state_n;
  half_t        upper_q;
  addr_t        pc_q;
  addr_t        pc_n;
  addr_t        pc_plus2;
  addr_t        pc_plus4;
  instr_t       jump_instr_q;
  addr_t        jump_addr_q;
  logic         hold_q;
  logic         update;
  logic         park;
  instr_t       instr_c;
  logic         valid_c;
  logic         compressed_c;
  logic         hold_c;

  assign pc_plus2 = pc_q + addr_t'(2);
  assign pc_plus4 = pc_q + addr_t'(4);

  // a jump under a decode stall is parked until the issue register drains
  assign park = branch_i && branch_is_jump_i && !is.take;

  ////////////////////////////////////////
  // state and pc
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ALIGNED32;
      pc_q    <= `FA_RESET_PC;
      hold_q  <= 1'b0;
    end else if (update) begin
      state_q <= state_n;
      pc_q    <= pc_n;
      // the held word is flushed anyway on a branch
      hold_q  <= hold_c && !branch_i;
    end
  end

  // upper parcel of the current word and the parked jump slot
  always_ff @(posedge clk) begin
    if (update) begin
      upper_q <= fw.word[31:16];
    end
    if (park) begin
      jump_instr_q <= instr_c;
      jump_addr_q  <= branch_addr_i;
    end
  end

  ////////////////////////////////////////
  // next state decode
  ////////////////////////////////////////

  always_comb begin
    state_n      = state_q;
    pc_n         = pc_q;
    instr_c      = fw.word;
    valid_c      = fw.valid;
    compressed_c = 1'b0;
    hold_c       = 1'b0;
    update       = 1'b0;

    unique case (state_q)
      // next instruction starts at the low half of the incoming word
      ALIGNED32, MISALIGNED16: begin
        // after a hold the word is still at the queue head
        valid_c = fw.valid || ((state_q == MISALIGNED16) && hold_q);
        update  = valid_c && is.take && !hold_state_i;
        if (fw.word[1:0] == 2'b11) begin
          state_n = ALIGNED32;
          pc_n    = pc_plus4;
        end else begin
          state_n      = ALIGNED16;
          pc_n         = pc_plus2;
          instr_c      = {16'b0, fw.word[15:0]};
          compressed_c = 1'b1;
        end
      end

      // next instruction starts at the stored upper parcel
      ALIGNED16, MISALIGNED32: begin
        if (upper_q[1:0] == 2'b11) begin
          // straddles the word boundary, low half comes from the new word
          state_n = MISALIGNED32;
          pc_n    = pc_plus4;
          instr_c = {fw.word[15:0], upper_q};
          update  = fw.valid && is.take && !hold_state_i;
        end else begin
          // the stored parcel is a whole instruction on its own
          state_n      = MISALIGNED16;
          pc_n         = pc_plus2;
          instr_c      = {16'b0, upper_q};
          compressed_c = 1'b1;
          valid_c      = 1'b1;
          // incoming word is untouched, keep it in the queue
          hold_c       = fw.valid;
          update       = is.take && !hold_state_i;
        end
      end

      // the target sits in the upper half of the first word
      BRANCH_MISALIGNED: begin
        update = fw.valid && is.take && !hold_state_i;
        if (fw.word[17:16] == 2'b11) begin
          // only half of it is here, store it and wait for the next word
          state_n = MISALIGNED32;
          valid_c = 1'b0;
        end else begin
          state_n      = ALIGNED32;
          pc_n         = pc_plus2;
          instr_c      = {16'b0, fw.word[31:16]};
          compressed_c = 1'b1;
        end
      end

      // decode still holds the jump, the slot behind it is never issued
      WAIT_VALID_BRANCH: begin
        state_n      = jump_addr_q[1] ? BRANCH_MISALIGNED : ALIGNED32;
        pc_n         = jump_addr_q;
        instr_c      = jump_instr_q;
        compressed_c = (jump_instr_q[1:0] != 2'b11);
        valid_c      = 1'b0;
        update       = is.take;
      end

      default: begin
        state_n = ALIGNED32;
      end
    endcase

    // a branch always moves the aligner, the queue restarts underneath
    if (branch_i) begin
      update = 1'b1;
      if (park) begin
        state_n = WAIT_VALID_BRANCH;
        pc_n    = pc_q;
      end else begin
        state_n = branch_addr_i[1] ? BRANCH_MISALIGNED : ALIGNED32;
        pc_n    = branch_addr_i;
      end
    end
  end

  ////////////////////////////////////////
  // outputs
  ////////////////////////////////////////

  assign fw.hold        = hold_c;
  // the parked slot keeps the queue head, the target word must stay
  assign fw.advance     = update && !branch_i && (state_q != WAIT_VALID_BRANCH);
  assign fw.branch      = branch_i;
  assign fw.branch_addr = branch_addr_i;

  assign is.instr      = instr_c;
  assign is.pc         = pc_q;
  assign is.compressed = compressed_c;
  // during a branch valid tells the issue register to keep its stalled jump
  assign is.valid      = branch_i ? park : (valid_c && !hold_state_i);

  // branch targets come from a halfword aligned instruction set
  a_target_half: assert property (
    @(posedge clk) disable iff (!rst_n)
    branch_i |-> !branch_addr_i[0]
  );

  // a held word must still be at the queue head in the next cycle
  a_hold_keeps_word: assert property (
    @(posedge clk) disable iff (!rst_n)
    (fw.hold && !branch_i) |=> fw.valid
  );

  a_state_legal: assert property (
    @(posedge clk) disable iff (!rst_n)
    state_q inside {ALIGNED32, ALIGNED16, MISALIGNED32, MISALIGNED16,
                    BRANCH_MISALIGNED, WAIT_VALID_BRANCH}
  );

endmodule

/* source/issue_if.sv */
/*
  Aligned instruction channel
  Carries one instruction with its pc and compressed flag from the
  aligner to the issue register, and the take level back
*/
`timescale 1ns/100ps

interface issue_if;
  import fetch_align_pkg::*;

  instr_t instr;
  addr_t  pc;
  logic   compressed;
  logic   valid;
  // the issue register can accept an instruction in this cycle
  // during a branch the valid line means the stalled slot is kept
  logic   take;

  modport source (
    output instr, pc, compressed, valid,
    input  take
  );

  modport sink (
    input  instr, pc, compressed, valid,
    output take
  );

endinterface

/* source/issue_stage_reg.sv */
/*
  Issue register
  One-entry holding register between the aligner and decode.
  Tells the aligner when it may advance and keeps a stalled jump
  alive across its own branch
*/
`timescale 1ns/100ps

module issue_stage_reg (
  input  logic                    clk,
  input  logic                    rst_n,
  issue_if.sink                   is,
  input  logic                    id_ready_i,
  input  logic                    branch_i,
  output fetch_align_pkg::instr_t id_instr_o,
  output fetch_align_pkg::addr_t  id_pc_o,
  output logic                    id_compressed_o,
  output logic                    id_valid_o
);
  import fetch_align_pkg::*;

  instr_t instr_q;
  addr_t  pc_q;
  logic   compressed_q;
  logic   valid_q;

  // free now, or decode takes the current entry in this cycle
  assign is.take = !valid_q || id_ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (branch_i) begin
      // keep the entry only when it is a stalled jump being parked
      valid_q <= !is.take && is.valid;
    end else if (is.take) begin
      valid_q <= is.valid;
    end
  end

  // the offer in a branch cycle belongs to the old stream
  always_ff @(posedge clk) begin
    if (!branch_i && is.take && is.valid) begin
      instr_q      <= is.instr;
      pc_q         <= is.pc;
      compressed_q <= is.compressed;
    end
  end

  assign id_instr_o      = instr_q;
  assign id_pc_o         = pc_q;
  assign id_compressed_o = compressed_q;
  assign id_valid_o      = valid_q;

  // decode sees a steady instruction until it accepts it
  a_hold_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (id_valid_o && !id_ready_i && !branch_i) |=>
      id_valid_o && $stable(id_instr_o) && $stable(id_pc_o) && $stable(id_compressed_o)
  );

endmodule
